// File: rtl/wb_master_settings.svh
// ========================================
// bus widths and burst length shared by the Wishbone master,
// its package and its testbench
// include this header wherever a width or the burst length is needed
// ========================================

`ifndef WB_MASTER_SETTINGS_SVH
`define WB_MASTER_SETTINGS_SVH

// byte address width on the bus
`define WB_ADDR_W 32

// data width on the bus, one word per beat
`define WB_DATA_W 32

// one select bit per byte lane
`define WB_SEL_W 4

// words in one cache line, fetched as a wrapping burst
`define WB_BURST_LEN 4

`endif

// File: rtl/wb_master_pkg.sv
// ========================================
// types shared by the Wishbone master RTL and its testbench
// import with wb_master_pkg::* inside a module body
// ========================================

`include "wb_master_settings.svh"

package wb_master_pkg;

    // bus sequencer states, a burst walks BURST1 to BURST3 then WAIT_ACK
    typedef enum logic [2:0] {
        ST_IDLE     = 3'd0,
        ST_BURST1   = 3'd1,
        ST_BURST2   = 3'd2,
        ST_BURST3   = 3'd3,
        ST_WAIT_ACK = 3'd4
    } wb_state_e;

    // which cache owns the access currently on the bus
    typedef enum logic [1:0] {
        SRC_NONE   = 2'd0,
        SRC_ICACHE = 2'd1,
        SRC_DCACHE = 2'd2
    } req_src_e;

    // instruction fetch request, reads only
    typedef struct packed {
        logic                   req;
        logic                   qword;
        logic [`WB_ADDR_W-1:0]  address;
    } icache_req_t;

    // data cache request, byte_enable only matters for writes
    typedef struct packed {
        logic                   req;
        logic                   qword;
        logic                   write;
        logic [`WB_SEL_W-1:0]   byte_enable;
        logic [`WB_ADDR_W-1:0]  address;
        logic [`WB_DATA_W-1:0]  write_data;
    } dcache_req_t;

    // the winning request as seen by the sequencer
    typedef struct packed {
        logic                   valid;
        logic                   we;
        logic                   qword;
        logic [`WB_SEL_W-1:0]   sel;
        logic [`WB_ADDR_W-1:0]  address;
        logic [`WB_DATA_W-1:0]  write_data;
    } bus_req_t;

    // Wishbone master outputs
    typedef struct packed {
        logic [`WB_ADDR_W-1:0]  adr;
        logic [`WB_SEL_W-1:0]   sel;
        logic                   we;
        logic [`WB_DATA_W-1:0]  dat;
        logic                   cyc;
        logic                   stb;
    } wb_out_t;

endpackage

// File: rtl/wb_request_arbiter.sv
// ========================================
// picks between instruction and data cache requests
// data requests always win over a pending instruction fetch
// returns read acks and write launches as ready pulses
// ========================================

`timescale 1ns/1ns

`include "wb_master_settings.svh"

module wb_request_arbiter
(
    input  logic                        i_clk,
    input  logic                        quick_n_reset,
    input  wb_master_pkg::icache_req_t  i_icache,
    input  wb_master_pkg::dcache_req_t  i_dcache,
    input  logic                        i_launch,
    input  logic                        i_read_ack,
    input  logic                        i_access_done,
    input  logic [`WB_DATA_W-1:0]       i_wb_dat,
    output wb_master_pkg::bus_req_t     o_bus_req,
    output logic                        o_icache_ready,
    output logic                        o_dcache_ready,
    output logic [`WB_DATA_W-1:0]       o_icache_read_data,
    output logic [`WB_DATA_W-1:0]       o_dcache_read_data
);

    import wb_master_pkg::*;

    // held copy of an instruction fetch, kept until its access completes
    logic                   icache_pend_r;
    logic                   icache_qword_r;
    logic [`WB_ADDR_W-1:0]  icache_addr_r;

    // source that owns the bus from launch until access_done
    req_src_e               src_r;

    // instruction request as offered this cycle, live or from the hold
    logic                   icache_valid_c;
    logic                   icache_qword_c;
    logic [`WB_ADDR_W-1:0]  icache_addr_c;

    // a live fetch request is new only while the icache is not being served
    logic                   icache_new_c;

    assign icache_new_c   = i_icache.req && (src_r != SRC_ICACHE);
    assign icache_valid_c = icache_pend_r || i_icache.req;
    assign icache_qword_c = icache_pend_r ? icache_qword_r : i_icache.qword;
    assign icache_addr_c  = icache_pend_r ? icache_addr_r : i_icache.address;

    // ========================================
    // request selection
    // ========================================

    always_comb
    begin
        if (i_dcache.req)
        begin
            o_bus_req.valid      = 1'b1;
            o_bus_req.we         = i_dcache.write;
            // bursts are reads only
            o_bus_req.qword      = i_dcache.qword && !i_dcache.write;
            o_bus_req.sel        = i_dcache.write ? i_dcache.byte_enable : '1;
            o_bus_req.address    = i_dcache.address;
            o_bus_req.write_data = i_dcache.write_data;
        end
        else
        begin
            o_bus_req.valid      = icache_valid_c;
            o_bus_req.we         = 1'b0;
            o_bus_req.qword      = icache_qword_c;
            o_bus_req.sel        = '1;
            o_bus_req.address    = icache_addr_c;
            o_bus_req.write_data = '0;
        end
    end

    // ========================================
    // pending fetch and owner tracking
    // ========================================

    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            icache_pend_r <= 1'b0;
            src_r         <= SRC_NONE;
        end
        else
        begin
            // the old fetch is still on req during its last ack, so clear wins here
            if (i_access_done && (src_r == SRC_ICACHE))
                icache_pend_r <= 1'b0;
            else if (icache_new_c)
                icache_pend_r <= 1'b1;

            // launch happens only in idle and access_done only in wait-ack
            if (i_launch)
                src_r <= i_dcache.req ? SRC_DCACHE : SRC_ICACHE;
            else if (i_access_done)
                src_r <= SRC_NONE;
        end
    end

    // fetch fields are captured on the first cycle the request shows up
    always_ff @(posedge i_clk)
    begin
        if (!icache_pend_r && icache_new_c)
        begin
            icache_qword_r <= i_icache.qword;
            icache_addr_r  <= i_icache.address;
        end
    end

    // ========================================
    // ready pulses and read data
    // ========================================

    assign o_icache_ready = i_read_ack && (src_r == SRC_ICACHE);

    // posted write, the data cache is released as soon as the write starts
    assign o_dcache_ready = (i_read_ack && (src_r == SRC_DCACHE))
                         || (i_launch && o_bus_req.we);

    // both caches see the bus data, the ready pulse says who owns it
    assign o_icache_read_data = i_wb_dat;
    assign o_dcache_read_data = i_wb_dat;

endmodule

// File: rtl/wb_cycle_sequencer.sv
// ========================================
// Wishbone bus state machine for the cache master
// loads the bus registers from the selected request in idle,
// steps wrapping burst addresses on each ack and ends the cycle
// reports launch, read acks and the end of each access
// ========================================

`timescale 1ns/1ns

`include "wb_master_settings.svh"

module wb_cycle_sequencer
(
    input  logic                     i_clk,
    input  logic                     quick_n_reset,
    input  wb_master_pkg::bus_req_t  i_bus_req,
    input  logic                     i_wb_ack,
    output wb_master_pkg::wb_out_t   o_wb,
    output logic                     o_launch,
    output logic                     o_read_ack,
    output logic                     o_access_done
);

    import wb_master_pkg::*;

    // word index bits inside a cache line, bits 3 to 2 for four words
    localparam int BEAT_W = $clog2(`WB_BURST_LEN);

    wb_state_e              state_r;

    // control outputs, cleared by reset
    logic                   wb_stb_r;
    logic                   wb_we_r;

    // address and data payload, only meaningful while stb is high
    logic [`WB_ADDR_W-1:0]  wb_adr_r;
    logic [`WB_SEL_W-1:0]   wb_sel_r;
    logic [`WB_DATA_W-1:0]  wb_dat_r;

    // an ack that moves a burst on to the next word
    logic                   burst_step_c;

    // the low address bits point at the lowest enabled lane
    // full-word and odd patterns fall back to lane 0
    function automatic logic [1:0] lane_offset(input logic [`WB_SEL_W-1:0] sel);
        logic [1:0] offset;
        case (sel)
            4'b0001: offset = 2'd0;
            4'b0010: offset = 2'd1;
            4'b0100: offset = 2'd2;
            4'b1000: offset = 2'd3;
            4'b0011: offset = 2'd0;
            4'b1100: offset = 2'd2;
            default: offset = 2'd0;
        endcase
        return offset;
    endfunction

    // a new access may only start from idle, which is never the cycle after stb
    assign o_launch      = (state_r == ST_IDLE) && i_bus_req.valid;
    assign o_read_ack    = i_wb_ack && wb_stb_r && !wb_we_r;
    assign o_access_done = (state_r == ST_WAIT_ACK) && i_wb_ack;

    assign burst_step_c  = i_wb_ack && ((state_r == ST_BURST1)
                                     || (state_r == ST_BURST2)
                                     || (state_r == ST_BURST3));

    // ========================================
    // state and control outputs
    // ========================================

    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            state_r  <= ST_IDLE;
            wb_stb_r <= 1'b0;
            wb_we_r  <= 1'b0;
        end
        else
        begin
            case (state_r)
                ST_IDLE:
                begin
                    if (o_launch)
                    begin
                        wb_stb_r <= 1'b1;
                        wb_we_r  <= i_bus_req.we;
                        // only reads fill a whole line
                        if (i_bus_req.qword && !i_bus_req.we)
                            state_r <= ST_BURST1;
                        else
                            state_r <= ST_WAIT_ACK;
                    end
                end

                // stb stays up through the burst, each ack moves one state on
                ST_BURST1:
                    if (i_wb_ack)
                        state_r <= ST_BURST2;

                ST_BURST2:
                    if (i_wb_ack)
                        state_r <= ST_BURST3;

                ST_BURST3:
                    if (i_wb_ack)
                        state_r <= ST_WAIT_ACK;

                // last or only word, the cycle ends on its ack
                ST_WAIT_ACK:
                    if (i_wb_ack)
                    begin
                        state_r  <= ST_IDLE;
                        wb_stb_r <= 1'b0;
                        wb_we_r  <= 1'b0;
                    end

                default:
                begin
                    state_r  <= ST_IDLE;
                    wb_stb_r <= 1'b0;
                    wb_we_r  <= 1'b0;
                end
            endcase
        end
    end

    // ========================================
    // address, select and write data
    // ========================================

    always_ff @(posedge i_clk)
    begin
        if (o_launch)
        begin
            wb_adr_r <= {i_bus_req.address[`WB_ADDR_W-1:2], lane_offset(i_bus_req.sel)};
            wb_sel_r <= i_bus_req.sel;
            wb_dat_r <= i_bus_req.write_data;
        end
        else if (burst_step_c)
        begin
            // wrap inside the line, the upper address bits never change
            wb_adr_r[BEAT_W+1:2] <= wb_adr_r[BEAT_W+1:2] + 1'b1;
        end
    end

    // cycle and strobe rise and fall together
    assign o_wb.adr = wb_adr_r;
    assign o_wb.sel = wb_sel_r;
    assign o_wb.we  = wb_we_r;
    assign o_wb.dat = wb_dat_r;
    assign o_wb.cyc = wb_stb_r;
    assign o_wb.stb = wb_stb_r;

endmodule

// File: rtl/wb_master_top.sv
// ========================================
// cache-side Wishbone master of the core
// instruction and data caches in, one Wishbone master port out
// the arbiter chooses the access, the sequencer runs the bus cycle
// ========================================

`timescale 1ns/1ns

`include "wb_master_settings.svh"

module wb_master_top
(
    input  logic                        i_clk,
    input  logic                        quick_n_reset,

    // instruction cache side
    input  wb_master_pkg::icache_req_t  i_icache,
    output logic                        o_icache_ready,
    output logic [`WB_DATA_W-1:0]       o_icache_read_data,

    // data cache side
    input  wb_master_pkg::dcache_req_t  i_dcache,
    output logic                        o_dcache_ready,
    output logic [`WB_DATA_W-1:0]       o_dcache_read_data,

    // Wishbone bus
    output wb_master_pkg::wb_out_t      o_wb,
    input  logic [`WB_DATA_W-1:0]       i_wb_dat,
    input  logic                        i_wb_ack
);

    import wb_master_pkg::*;

    // selected access from the arbiter
    bus_req_t  bus_req;

    // progress pulses back from the sequencer
    logic      launch;
    logic      read_ack;
    logic      access_done;

    wb_request_arbiter u_arbiter
    (
        .i_clk              (i_clk),
        .quick_n_reset      (quick_n_reset),
        .i_icache           (i_icache),
        .i_dcache           (i_dcache),
        .i_launch           (launch),
        .i_read_ack         (read_ack),
        .i_access_done      (access_done),
        .i_wb_dat           (i_wb_dat),
        .o_bus_req          (bus_req),
        .o_icache_ready     (o_icache_ready),
        .o_dcache_ready     (o_dcache_ready),
        .o_icache_read_data (o_icache_read_data),
        .o_dcache_read_data (o_dcache_read_data)
    );

    wb_cycle_sequencer u_sequencer
    (
        .i_clk              (i_clk),
        .quick_n_reset      (quick_n_reset),
        .i_bus_req          (bus_req),
        .i_wb_ack           (i_wb_ack),
        .o_wb               (o_wb),
        .o_launch           (launch),
        .o_read_ack         (read_ack),
        .o_access_done      (access_done)
    );

endmodule

// File: verification/wb_master_props.sv
// ========================================
// bus and state machine properties of the Wishbone sequencer
// attached to every sequencer instance through bind
// ========================================

`timescale 1ns/1ns

module wb_master_props
(
    input logic                       i_clk,
    input logic                       quick_n_reset,
    input wb_master_pkg::wb_out_t     i_wb,
    input logic                       i_wb_ack,
    input wb_master_pkg::wb_state_e   i_state
);

    import wb_master_pkg::*;

    // the strobe is up exactly while the state machine is away from idle
    a_stb_busy: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        i_wb.stb == (i_state != ST_IDLE))
        else $error("stb does not match the sequencer state");

    // a burst walks one state per ack, then the cycle ends
    a_burst1: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (i_state == ST_BURST1 && i_wb_ack) |=> (i_state == ST_BURST2))
        else $error("burst1 did not step to burst2 on ack");
    a_burst2: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (i_state == ST_BURST2 && i_wb_ack) |=> (i_state == ST_BURST3))
        else $error("burst2 did not step to burst3 on ack");
    a_burst3: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (i_state == ST_BURST3 && i_wb_ack) |=> (i_state == ST_WAIT_ACK))
        else $error("burst3 did not step to wait-ack on ack");
    a_done: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (i_state == ST_WAIT_ACK && i_wb_ack) |=> (i_state == ST_IDLE && !i_wb.stb))
        else $error("access did not end after the final ack");

    // the slave may take its time, the master holds the beat
    a_hold: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (i_wb.stb && !i_wb_ack) |=> $stable({i_wb.adr, i_wb.sel, i_wb.we, i_wb.dat}))
        else $error("bus payload changed while waiting for ack");

endmodule

bind wb_cycle_sequencer wb_master_props u_props
(
    .i_clk         (i_clk),
    .quick_n_reset (quick_n_reset),
    .i_wb          (o_wb),
    .i_wb_ack      (i_wb_ack),
    .i_state       (state_r)
);

// File: verification/tb_wb_master.sv
// ========================================
// testbench for the cache-side Wishbone master
// random fetches, data reads and posted writes from an xorshift source,
// a Wishbone slave with random ack delay and a reference memory model
// stops at the first mismatch, or passes after all transactions drain
// ========================================

`timescale 1ns/1ns

`include "wb_master_settings.svh"

module tb_wb_master;

    import wb_master_pkg::*;

    localparam int NUM_TRANS   = 400;
    localparam int CYCLE_LIMIT = 60 * NUM_TRANS;

    // one expected bus beat, last marks the final word of an access
    typedef struct packed {
        logic [`WB_ADDR_W-1:0] adr;
        logic [`WB_SEL_W-1:0]  sel;
        logic                  we;
        logic [`WB_DATA_W-1:0] dat;
        logic                  last;
    } beat_t;

    logic                   i_clk;
    logic                   quick_n_reset;
    icache_req_t            icache;
    dcache_req_t            dcache;
    logic                   icache_ready;
    logic                   dcache_ready;
    logic [`WB_DATA_W-1:0]  icache_rdata;
    logic [`WB_DATA_W-1:0]  dcache_rdata;
    wb_out_t                wb;
    logic [`WB_DATA_W-1:0]  wb_dat;
    logic                   wb_ack;

    // ref_mem follows the requests, slave_mem follows what the bus really wrote
    logic [`WB_DATA_W-1:0]  ref_mem   [0:255];
    logic [`WB_DATA_W-1:0]  slave_mem [0:255];

    beat_t                  exp_beats [$];
    logic [`WB_DATA_W-1:0]  exp_idata [$];
    logic [`WB_DATA_W-1:0]  exp_ddata [$];

    logic [31:0]            rng_state;
    int                     cycle_count;
    int                     icache_pulses;
    int                     dcache_pulses;
    int                     delay_left;
    bit                     beat_open;
    bit                     stb_must_fall;
    bit                     dcache_write_active;

    wb_master_top u_dut
    (
        .i_clk              (i_clk),
        .quick_n_reset      (quick_n_reset),
        .i_icache           (icache),
        .o_icache_ready     (icache_ready),
        .o_icache_read_data (icache_rdata),
        .i_dcache           (dcache),
        .o_dcache_ready     (dcache_ready),
        .o_dcache_read_data (dcache_rdata),
        .o_wb               (wb),
        .i_wb_dat           (wb_dat),
        .i_wb_ack           (wb_ack)
    );

    // 4 ns clock
    always #2 i_clk = ~i_clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // byte lanes replace only where the enable bit is set
    function automatic logic [`WB_DATA_W-1:0] merge_lanes(input logic [`WB_DATA_W-1:0] old_word,
                                                          input logic [`WB_DATA_W-1:0] new_word,
                                                          input logic [`WB_SEL_W-1:0] be);
        logic [`WB_DATA_W-1:0] result;
        result = old_word;
        for (int b = 0; b < `WB_SEL_W; b++)
            if (be[b])
                result[8*b +: 8] = new_word[8*b +: 8];
        return result;
    endfunction

    // low address bits of a write, single lanes and aligned halves keep their offset
    function automatic logic [1:0] write_low_bits(input logic [`WB_SEL_W-1:0] be);
        case (be)
            4'b0010: return 2'd1;
            4'b0100: return 2'd2;
            4'b1100: return 2'd2;
            4'b1000: return 2'd3;
            default: return 2'd0;
        endcase
    endfunction

    task automatic stop_on_error(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_idle_outputs();
        assert (!wb.cyc && !wb.stb && !wb.we && !icache_ready && !dcache_ready)
            else stop_on_error("bus or ready output high in or right after reset");
    endtask

    // ========================================
    // slave model, driven 1 ns after each rising edge
    // ========================================

    task automatic drive_slave();
        wb_ack = 1'b0;
        wb_dat = '0;
        if (!wb.stb)
            beat_open = 1'b0;
        else
        begin
            // each word gets its own wait of 0 to 3 cycles
            if (!beat_open)
            begin
                delay_left = int'(next_random() % 32'd4);
                beat_open  = 1'b1;
            end
            if (delay_left == 0)
            begin
                wb_ack    = 1'b1;
                beat_open = 1'b0;
                if (wb.we)
                    slave_mem[wb.adr[9:2]] = merge_lanes(slave_mem[wb.adr[9:2]], wb.dat, wb.sel);
                else
                    wb_dat = slave_mem[wb.adr[9:2]];
            end
            else
                delay_left--;
        end
    endtask

    // ========================================
    // checks, sampled mid-cycle at the falling edge
    // ========================================

    task automatic check_cycle();
        beat_t                 want_beat;
        logic [`WB_DATA_W-1:0] want_data;
        // cycle and strobe always move together
        assert (wb.cyc == wb.stb)
            else stop_on_error($sformatf("cyc %b, expected %b", wb.cyc, wb.stb));
        if (stb_must_fall)
            assert (!wb.stb) else stop_on_error("stb still high after the last ack");
        stb_must_fall = 1'b0;
        if (wb_ack)
        begin
            assert (exp_beats.size() > 0) else stop_on_error("bus beat with no access expected");
            want_beat = exp_beats.pop_front();
            assert (wb.adr == want_beat.adr)
                else stop_on_error($sformatf("adr %h, expected %h", wb.adr, want_beat.adr));
            assert (wb.sel == want_beat.sel)
                else stop_on_error($sformatf("sel %b, expected %b", wb.sel, want_beat.sel));
            assert (wb.we == want_beat.we)
                else stop_on_error($sformatf("we %b, expected %b", wb.we, want_beat.we));
            if (want_beat.we)
                assert (wb.dat == want_beat.dat)
                    else stop_on_error($sformatf("dat %h, expected %h", wb.dat, want_beat.dat));
            stb_must_fall = want_beat.last;
        end
        if (icache_ready)
        begin
            assert (wb_ack && exp_idata.size() > 0)
                else stop_on_error("icache ready without a fetch ack");
            want_data = exp_idata.pop_front();
            assert (icache_rdata == want_data)
                else stop_on_error($sformatf("icache data %h, expected %h",
                                             icache_rdata, want_data));
            icache_pulses++;
        end
        if (dcache_ready)
        begin
            // a posted write is released at launch, before stb rises
            if (dcache_write_active)
            begin
                assert (!wb.stb) else stop_on_error("write ready while the bus is busy");
            end
            else
            begin
                assert (wb_ack && exp_ddata.size() > 0)
                    else stop_on_error("dcache ready without a read ack");
                want_data = exp_ddata.pop_front();
                assert (dcache_rdata == want_data)
                    else stop_on_error($sformatf("dcache data %h, expected %h",
                                                 dcache_rdata, want_data));
            end
            dcache_pulses++;
        end
    endtask

    task automatic next_cycle();
        @(negedge i_clk);
        check_cycle();
        @(posedge i_clk);
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("timeout: the bus made no progress within %0d cycles", cycle_count);
            $display("TEST RESULT: FAIL");
            $fatal(1, "simulation stopped by the cycle limit");
        end
        #1;
        drive_slave();
    endtask

    // ========================================
    // expected traffic and request driving
    // ========================================

    task automatic queue_reads(input logic [`WB_ADDR_W-1:0] addr, input logic qword,
                               input bit to_icache);
        beat_t      b;
        logic [1:0] word;
        int         beats;
        beats = qword ? `WB_BURST_LEN : 1;
        for (int k = 0; k < beats; k++)
        begin
            // wrapping order inside the line, starting at the requested word
            word   = addr[3:2] + 2'(k);
            b.adr  = {addr[`WB_ADDR_W-1:4], word, 2'b00};
            b.sel  = '1;
            b.we   = 1'b0;
            b.dat  = '0;
            b.last = (k == beats - 1);
            exp_beats.push_back(b);
            if (to_icache)
                exp_idata.push_back(ref_mem[{addr[9:4], word}]);
            else
                exp_ddata.push_back(ref_mem[{addr[9:4], word}]);
        end
    endtask

    task automatic queue_write(input dcache_req_t d);
        beat_t b;
        b.adr  = {d.address[`WB_ADDR_W-1:2], write_low_bits(d.byte_enable)};
        b.sel  = d.byte_enable;
        b.we   = 1'b1;
        b.dat  = d.write_data;
        b.last = 1'b1;
        exp_beats.push_back(b);
        ref_mem[d.address[9:2]] = merge_lanes(ref_mem[d.address[9:2]],
                                              d.write_data, d.byte_enable);
    endtask

    // data side is queued first, it must reach the bus first
    task automatic run_access(input icache_req_t ireq, input dcache_req_t dreq);
        int i_need;
        int d_need;
        i_need = 0;
        d_need = 0;
        if (dreq.req && dreq.write)
        begin
            queue_write(dreq);
            d_need = 1;
        end
        else if (dreq.req)
        begin
            queue_reads(dreq.address, dreq.qword, 1'b0);
            d_need = dreq.qword ? `WB_BURST_LEN : 1;
        end
        if (ireq.req)
        begin
            queue_reads(ireq.address, ireq.qword, 1'b1);
            i_need = ireq.qword ? `WB_BURST_LEN : 1;
        end
        icache_pulses       = 0;
        dcache_pulses       = 0;
        dcache_write_active = dreq.req && dreq.write;
        icache              = ireq;
        dcache              = dreq;
        while (icache.req || dcache.req)
        begin
            next_cycle();
            if (icache.req && (icache_pulses == i_need))
                icache = '0;
            if (dcache.req && (dcache_pulses == d_need))
                dcache = '0;
        end
    endtask

    initial
    begin
        icache_req_t ireq;
        dcache_req_t dreq;
        logic [31:0] r;
        int          kind;
        i_clk               = 1'b0;
        quick_n_reset       = 1'b0;
        icache              = '0;
        dcache              = '0;
        wb_ack              = 1'b0;
        wb_dat              = '0;
        rng_state           = 32'heb85_13a4;
        cycle_count         = 0;
        delay_left          = 0;
        beat_open           = 1'b0;
        stb_must_fall       = 1'b0;
        dcache_write_active = 1'b0;
        // fill word depends on every bit of the word index
        for (int i = 0; i < 256; i++)
        begin
            ref_mem[i]   = {~i[7:0], i[7:0] ^ 8'h5a, i[7:0], i[7:0] ^ 8'h3c};
            slave_mem[i] = ref_mem[i];
        end

        repeat (3)
        begin
            @(posedge i_clk);
            #1;
            check_idle_outputs();
        end
        quick_n_reset = 1'b1;
        // first cycle after the first edge that sees reset released
        @(posedge i_clk);
        #1;
        check_idle_outputs();

        for (int t = 0; t < NUM_TRANS; t++)
        begin
            ireq = '0;
            dreq = '0;
            kind = int'(next_random() % 32'd5);
            r    = next_random();
            // only 32 words are used so writes and reads often meet
            ireq.address = r & 32'hffff_fc7f;
            ireq.qword   = r[12];
            r    = next_random();
            dreq.address     = r & 32'hffff_fc7f;
            dreq.qword       = r[12];
            dreq.byte_enable = r[23:20];
            dreq.write_data  = next_random();
            ireq.req    = (kind == 0) || (kind == 4);
            dreq.req    = (kind != 0);
            dreq.write  = (kind == 2) || (kind == 3) || ((kind == 4) && r[28]);
            if (dreq.write)
                dreq.qword = 1'b0;
            run_access(ireq, dreq);
            repeat (int'(next_random() % 32'd3))
                next_cycle();
        end

        // let the last posted write finish on the bus
        while ((exp_beats.size() > 0) || wb.stb)
            next_cycle();
        next_cycle();

        if ((exp_idata.size() == 0) && (exp_ddata.size() == 0))
        begin
            $display("TEST RESULT: PASS");
            $finish;
        end
        else
            stop_on_error("read responses still missing at the end of the run");
    end

endmodule

// File: build.f
+incdir+rtl
rtl/wb_master_pkg.sv
rtl/wb_request_arbiter.sv
rtl/wb_cycle_sequencer.sv
rtl/wb_master_top.sv
verification/wb_master_props.sv
verification/tb_wb_master.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the Wishbone master testbench with Verilator and runs it
# the exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_wb_master \
    -Mdir obj_dir \
    -f build.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit "$status"
fi

./obj_dir/Vtb_wb_master
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

exit 0
